// File: Makefile
# Verilator build and run of the CAM BIST testbench
TOP = cam_bist_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "All tests passed"

clean:
	rm -rf obj_dir

// File: dv/cam_bist_tb.sv
/*
  Directed testbench for the CAM BIST datapath. Inputs change on the falling edge.
  A model array predicts every read and search result from the command rules.
*/
module cam_bist_tb import cam_geom_pkg::*, cam_bist_ops_pkg::*;;

  localparam int TIMEOUT = 20;

  logic                  bist_clk;
  logic                  rst_n;
  logic                  cmd_valid;
  bist_op_e              cmd_op;
  logic [RF_AWIDTH-1:0]  cmd_addr;
  logic [RF_DWIDTH-1:0]  cmd_data;
  match_sel_e            cmd_match_sel;
  logic                  out_valid;
  logic [RF_DWIDTH-1:0]  rd_data_out;
  logic [RF_ENTRIES-1:0] match_ref;
  logic                  cmp_fail;

  // Reference model of the array
  logic [RF_DWIDTH-1:0]  model_mem [RF_ENTRIES];
  logic [RF_ENTRIES-1:0] model_vld;
  logic [31:0]           rng_state = 32'd30;
  int                    errors = 0;
  int                    n_pass = 0;
  int                    n_fail = 0;
  logic [RF_DWIDTH-1:0]  base;

  cam_bist_top dut_i (.*);

  initial begin
    bist_clk = 1'b0;
    forever #10 bist_clk = ~bist_clk;
  end

  // ========================================
  // Model and helpers
  // ========================================

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  // Valid entry holding the key hits
  function automatic logic [RF_ENTRIES-1:0] model_match(logic [RF_DWIDTH-1:0] key);
    logic [RF_ENTRIES-1:0] m;
    for (int e = 0; e < RF_ENTRIES; e++) m[e] = model_vld[e] && (model_mem[e] == key);
    return m;
  endfunction

  function automatic logic [RF_ENTRIES-1:0] expected_lines(match_sel_e sel, int addr);
    logic [RF_ENTRIES-1:0] one;
    one = '0;
    one[addr] = 1'b1;
    if (sel == MATCH_ALL) return '1;
    if (sel == MATCH_SINGLE) return one;
    if (sel == MISMATCH_SINGLE) return ~one;
    return '0;
  endfunction

  // Output bit i is the OR of lines i, i+8, i+16, i+24
  function automatic logic [RF_DWIDTH-1:0] fold_lines(logic [RF_ENTRIES-1:0] v);
    logic [RF_DWIDTH-1:0] f;
    f = '0;
    for (int j = 0; j < RF_ENTRIES; j++) f[j % RF_DWIDTH] |= v[j];
    return f;
  endfunction

  task automatic check_data(string name, logic [RF_DWIDTH-1:0] exp, logic [RF_DWIDTH-1:0] act);
    if (act !== exp) begin
      $display("** Error: %s expected 0x%h got 0x%h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_ref(string name, logic [RF_ENTRIES-1:0] exp,
                           logic [RF_ENTRIES-1:0] act);
    if (act !== exp) begin
      $display("** Error: %s expected 0x%h got 0x%h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("** Error: %s expected 0x%h got 0x%h", name, exp, act);
      errors++;
    end
  endtask

  // ========================================
  // Command driving and result waiting
  // ========================================

  task automatic drive_cmd(bist_op_e op, int addr, logic [RF_DWIDTH-1:0] data, match_sel_e sel);
    @(negedge bist_clk);
    cmd_valid     = 1'b1;
    cmd_op        = op;
    cmd_addr      = RF_AWIDTH'(addr);
    cmd_data      = data;
    cmd_match_sel = sel;
    if (op == BIST_WRITE) begin
      model_mem[addr] = data;
      model_vld[addr] = 1'b1;
    end
  endtask

  task automatic drive_idle();
    @(negedge bist_clk);
    cmd_valid = 1'b0;
  endtask

  // Returns falling edges waited, or -1 on timeout
  task automatic wait_result(output int waited);
    waited = -1;
    for (int n = 0; n < TIMEOUT; n++) begin
      if (out_valid === 1'b1) begin
        waited = n;
        break;
      end
      @(negedge bist_clk);
    end
    if (waited < 0) begin
      $display("out_valid never rose: no result before timeout");
      errors++;
    end
  endtask

  task automatic check_search(int addr, logic [RF_DWIDTH-1:0] key, match_sel_e sel);
    logic [RF_ENTRIES-1:0] exp_ref;
    logic [RF_ENTRIES-1:0] diff;
    exp_ref = expected_lines(sel, addr);
    diff    = exp_ref ^ model_match(key);
    check_ref("match_ref", exp_ref, match_ref);
    check_data("rd_data_out", fold_lines(diff), rd_data_out);
    check_flag("cmp_fail", |diff, cmp_fail);
  endtask

  task automatic check_read(int addr);
    check_data("rd_data_out", model_mem[addr], rd_data_out);
    check_flag("cmp_fail", 1'b0, cmp_fail);
  endtask

  task automatic do_write(int addr, logic [RF_DWIDTH-1:0] data);
    drive_cmd(BIST_WRITE, addr, data, MATCH_ALL);
    drive_idle();
  endtask

  task automatic do_read(int addr);
    int w;
    drive_cmd(BIST_READ, addr, '0, MATCH_ALL);
    drive_idle();
    wait_result(w);
    if (w >= 0) check_read(addr);
  endtask

  task automatic do_search(int addr, logic [RF_DWIDTH-1:0] key, match_sel_e sel);
    int w;
    drive_cmd(BIST_SEARCH, addr, key, sel);
    drive_idle();
    wait_result(w);
    if (w >= 0) check_search(addr, key, sel);
  endtask

  task automatic finish_test(string name, int errs_before);
    if (errors == errs_before) begin
      n_pass++;
      $display("PASS  %s", name);
    end else begin
      n_fail++;
      $display("FAIL  %s (%0d errors)", name, errors - errs_before);
    end
  endtask

  // ========================================
  // Directed tests
  // ========================================

  task automatic test_reset_state();
    int e0;
    e0 = errors;
    do_search(3, RF_DWIDTH'(xorshift32()), MISMATCH_ALL);
    finish_test("reset state", e0);
  endtask

  task automatic test_write_read();
    int e0;
    e0 = errors;
    for (int a = 0; a < 6; a++) do_write(a * 5, RF_DWIDTH'(xorshift32()));
    for (int a = 0; a < 6; a++) do_read(a * 5);
    finish_test("write then read", e0);
  endtask

  // Entries differ in bits 7:3, so every entry is unique
  task automatic test_single_match();
    int e0;
    e0 = errors;
    base = RF_DWIDTH'(xorshift32());
    for (int a = 0; a < RF_ENTRIES; a++) do_write(a, base + RF_DWIDTH'(a * 8));
    for (int a = 0; a < RF_ENTRIES; a++) do_search(a, model_mem[a], MATCH_SINGLE);
    finish_test("single-match search", e0);
  endtask

  task automatic test_pattern_disagree();
    int e0;
    e0 = errors;
    do_search(9, model_mem[9], MATCH_ALL);
    check_flag("cmp_fail", 1'b1, cmp_fail);
    finish_test("expected pattern disagrees", e0);
  endtask

  // Low bits of base plus one match no entry
  task automatic test_all_mismatch();
    int e0;
    e0 = errors;
    do_search(5, base + 8'd1, MISMATCH_ALL);
    check_flag("cmp_fail", 1'b0, cmp_fail);
    do_search(5, base + 8'd1, MISMATCH_SINGLE);
    check_flag("cmp_fail", 1'b1, cmp_fail);
    finish_test("all-mismatch search", e0);
  endtask

  task automatic test_back_to_back();
    int e0;
    int w;
    e0 = errors;
    drive_cmd(BIST_SEARCH, 10, model_mem[10], MATCH_SINGLE);
    drive_cmd(BIST_READ, 20, '0, MATCH_ALL);
    drive_idle();
    // First result lands two cycles after its strobe
    wait_result(w);
    if (w > 0) begin
      $display("Search result came later than two cycles after its strobe");
      errors++;
    end
    if (w >= 0) check_search(10, model_mem[10], MATCH_SINGLE);
    @(negedge bist_clk);
    wait_result(w);
    if (w > 0) begin
      $display("Read result did not follow the search in the next cycle");
      errors++;
    end
    if (w >= 0) check_read(20);
    finish_test("back-to-back commands", e0);
  endtask

  initial begin
    rst_n         = 1'b0;
    cmd_valid     = 1'b0;
    cmd_op        = BIST_WRITE;
    cmd_addr      = '0;
    cmd_data      = '0;
    cmd_match_sel = MATCH_ALL;
    model_vld     = '0;
    base          = '0;
    repeat (8) @(posedge bist_clk);
    @(negedge bist_clk);
    rst_n = 1'b1;
    test_reset_state();
    test_write_read();
    test_single_match();
    test_pattern_disagree();
    test_all_mismatch();
    test_back_to_back();
    $display("Tests passed: %0d  failed: %0d", n_pass, n_fail);
    if (n_fail == 0 && errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: source/cam_array.sv
/*
  Behavioral CAM with per-entry valid bits. Data words have no reset.
  Writes take effect at the sampling edge; reads and searches return PIPE_DEPTH cycles later.
*/
module cam_array import cam_geom_pkg::*, cam_bist_ops_pkg::*; (
  input logic     bist_clk,
  input logic     rst_n,
  cam_req_if.cam  req,
  cam_rsp_if.cam  rsp
);

  // Entry storage
  logic [RF_DWIDTH-1:0]  mem [RF_ENTRIES];
  logic [RF_ENTRIES-1:0] ent_vld;

  // Command-cycle results
  logic                  lookup;
  logic [RF_DWIDTH-1:0]  rd_data_c;
  logic [RF_ENTRIES-1:0] match_c;

  // Result pipeline
  logic [PIPE_DEPTH-1:0] vld_q;
  bist_op_e              op_q [PIPE_DEPTH];
  logic [RF_DWIDTH-1:0]  rd_q [PIPE_DEPTH];
  logic [RF_ENTRIES-1:0] ml_q [PIPE_DEPTH];

  // ========================================
  // Write port
  // ========================================

  always_ff @(posedge bist_clk or negedge rst_n) begin
    if (!rst_n) begin
      ent_vld <= '0;
    end else if (req.valid && req.op == BIST_WRITE) begin
      ent_vld[req.addr] <= 1'b1;
    end
  end

  always_ff @(posedge bist_clk) begin
    if (req.valid && req.op == BIST_WRITE) begin
      mem[req.addr] <= req.data;
    end
  end

  // ========================================
  // Read and search, command cycle
  // ========================================

  // Only reads and searches produce a result
  assign lookup    = req.valid && req.op != BIST_WRITE;
  assign rd_data_c = mem[req.addr];

  // A line hits on a valid entry holding the key
  always_comb begin
    for (int e = 0; e < RF_ENTRIES; e++) begin
      match_c[e] = ent_vld[e] && (mem[e] == req.data);
    end
  end

  // ========================================
  // Result pipeline
  // ========================================

  always_ff @(posedge bist_clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[PIPE_DEPTH-2:0], lookup};
    end
  end

  // Payload follows the strobe, no reset
  always_ff @(posedge bist_clk) begin
    op_q[0] <= req.op;
    rd_q[0] <= rd_data_c;
    ml_q[0] <= match_c;
    for (int s = 1; s < PIPE_DEPTH; s++) begin
      op_q[s] <= op_q[s-1];
      rd_q[s] <= rd_q[s-1];
      ml_q[s] <= ml_q[s-1];
    end
  end

  assign rsp.valid       = vld_q[PIPE_DEPTH-1];
  assign rsp.op          = op_q[PIPE_DEPTH-1];
  assign rsp.rd_data     = rd_q[PIPE_DEPTH-1];
  assign rsp.match_lines = ml_q[PIPE_DEPTH-1];

  // Controller must never strobe an undefined op
  a_req_op_known : assert property (@(posedge bist_clk) disable iff (!rst_n)
    req.valid |-> !$isunknown(req.op));

endmodule

// File: source/cam_bist_ops_pkg.sv
/*
  Command and expected-match encodings seen by the CAM BIST datapath.
*/
package cam_bist_ops_pkg;

  // Test command issued by the external controller
  typedef enum logic [1:0] {
    BIST_WRITE  = 2'b00,
    BIST_READ   = 2'b01,
    BIST_SEARCH = 2'b10
  } bist_op_e;

  // ========================================
  // Expected search outcome
  // ========================================

  // Pattern of match lines the controller expects for a search
  typedef enum logic [1:0] {
    MATCH_ALL       = 2'b00,  // every line hits
    MATCH_SINGLE    = 2'b01,  // only the addressed line hits
    MISMATCH_SINGLE = 2'b10,  // all but the addressed line hit
    MISMATCH_ALL    = 2'b11   // no line hits
  } match_sel_e;

endpackage

// File: source/cam_bist_outhandler.sv
/*
  Compares real and expected match lines and compacts the difference 4:1 onto read data.
  Purely combinational; inputs must already be aligned to the same command.
*/
module cam_bist_outhandler import cam_geom_pkg::*, cam_bist_ops_pkg::*; (
  cam_rsp_if.oh                 rsp,
  input  logic [RF_ENTRIES-1:0] match_ref,
  output logic                  out_valid,
  output logic [RF_DWIDTH-1:0]  rd_data_out,
  output logic                  cmp_fail
);

  // Per-line disagreement
  logic [RF_ENTRIES-1:0] diff;
  // Compacted disagreement
  logic [RF_DWIDTH-1:0]  fold;
  logic                  is_search;

  // ========================================
  // Match comparator
  // ========================================

  // A set bit marks a line that differs from expectation
  assign diff = match_ref ^ rsp.match_lines;

  // ========================================
  // 32-to-8 compactor
  // ========================================

  // Bit i collects lines i, i+8, i+16, i+24
  always_comb begin
    fold = '0;
    for (int i = 0; i < RF_DWIDTH; i++) begin
      for (int k = 0; k < FOLD; k++) begin
        fold[i] = fold[i] | diff[i + k * RF_DWIDTH];
      end
    end
  end

  // ========================================
  // Read-data mux and fail flag
  // ========================================

  assign is_search = rsp.op == BIST_SEARCH;

  assign out_valid = rsp.valid;

  // Search shows the folded compare, read passes array data
  assign rd_data_out = is_search ? fold : rsp.rd_data;

  // Any differing line fails a search
  assign cmp_fail = rsp.valid && is_search && (|diff);

endmodule

// File: source/cam_bist_top.sv
/*
  CAM BIST datapath top. One command per cycle, no back-pressure.
  Results appear two cycles after the strobe and hold for one cycle.
*/
module cam_bist_top import cam_geom_pkg::*, cam_bist_ops_pkg::*; (
  input  logic                  bist_clk,
  input  logic                  rst_n,

  // Command from the external test controller
  input  logic                  cmd_valid,
  input  bist_op_e              cmd_op,
  input  logic [RF_AWIDTH-1:0]  cmd_addr,
  input  logic [RF_DWIDTH-1:0]  cmd_data,
  input  match_sel_e            cmd_match_sel,

  // Aligned result
  output logic                  out_valid,
  output logic [RF_DWIDTH-1:0]  rd_data_out,
  output logic [RF_ENTRIES-1:0] match_ref,
  output logic                  cmp_fail
);

  // ========================================
  // Internal buses
  // ========================================

  cam_req_if req_if ();
  cam_rsp_if rsp_if ();

  // Command fans out to both parallel blocks
  assign req_if.valid     = cmd_valid;
  assign req_if.op        = cmd_op;
  assign req_if.addr      = cmd_addr;
  assign req_if.data      = cmd_data;
  assign req_if.match_sel = cmd_match_sel;

  // ========================================
  // Parallel blocks and output handler
  // ========================================

  cam_array array_i (
    .bist_clk (bist_clk),
    .rst_n    (rst_n),
    .req      (req_if.cam),
    .rsp      (rsp_if.cam)
  );

  cam_match_ref_gen ref_gen_i (
    .bist_clk  (bist_clk),
    .rst_n     (rst_n),
    .req       (req_if.ref_gen),
    .match_ref (match_ref)
  );

  cam_bist_outhandler oh_i (
    .rsp         (rsp_if.oh),
    .match_ref   (match_ref),
    .out_valid   (out_valid),
    .rd_data_out (rd_data_out),
    .cmp_fail    (cmp_fail)
  );

endmodule

// File: source/cam_geom_pkg.sv
/*
  Geometry of the CAM under test and of its BIST result path.
  RF_ENTRIES must be a whole multiple of RF_DWIDTH; only the 4:1 fold is supported.
*/
package cam_geom_pkg;

  // ========================================
  // Array geometry
  // ========================================

  // Number of CAM entries
  localparam int unsigned RF_ENTRIES = 32;

  // Entry width, also the read-data path width
  localparam int unsigned RF_DWIDTH = 8;

  // Entry address width
  localparam int unsigned RF_AWIDTH = $clog2(RF_ENTRIES);

  // ========================================
  // Derived test path widths
  // ========================================

  // Match lines OR-ed into one read-data bit
  localparam int unsigned FOLD = RF_ENTRIES / RF_DWIDTH;

  // Register stages from command strobe to result
  localparam int unsigned PIPE_DEPTH = 2;

endpackage

// File: source/cam_match_ref_gen.sv
/*
  Expected match vector, aligned with the CAM array result pipeline.
  Output is meaningful only in the cycle the aligned result is valid.
*/
module cam_match_ref_gen import cam_geom_pkg::*, cam_bist_ops_pkg::*; (
  input  logic                  bist_clk,
  input  logic                  rst_n,
  cam_req_if.ref_gen            req,
  output logic [RF_ENTRIES-1:0] match_ref
);

  // Delayed command fields
  logic [PIPE_DEPTH-1:0] vld_q;
  logic [RF_AWIDTH-1:0]  addr_q [PIPE_DEPTH];
  match_sel_e            sel_q [PIPE_DEPTH];
  logic [RF_ENTRIES-1:0] onehot;

  // ========================================
  // Alignment stages
  // ========================================

  always_ff @(posedge bist_clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[PIPE_DEPTH-2:0], req.valid};
    end
  end

  always_ff @(posedge bist_clk) begin
    addr_q[0] <= req.addr;
    sel_q[0]  <= req.match_sel;
    for (int s = 1; s < PIPE_DEPTH; s++) begin
      addr_q[s] <= addr_q[s-1];
      sel_q[s]  <= sel_q[s-1];
    end
  end

  // ========================================
  // Decode and pattern select
  // ========================================

  // One-hot line of the addressed entry
  assign onehot = RF_ENTRIES'(1) << addr_q[PIPE_DEPTH-1];

  always_comb begin
    case (sel_q[PIPE_DEPTH-1])
      MATCH_ALL:       match_ref = '1;
      MATCH_SINGLE:    match_ref = onehot;
      MISMATCH_SINGLE: match_ref = ~onehot;
      MISMATCH_ALL:    match_ref = '0;
      default:         match_ref = '0;
    endcase
  end

  // Single-match expectation names exactly one line
  a_single_onehot : assert property (@(posedge bist_clk) disable iff (!rst_n)
    (vld_q[PIPE_DEPTH-1] && sel_q[PIPE_DEPTH-1] == MATCH_SINGLE) |-> $onehot(match_ref));

endmodule

// File: source/cam_req_if.sv
/*
  One BIST command, seen by the CAM array and the expected-match generator alike.
  valid is a single-cycle strobe with no back-pressure.
*/
interface cam_req_if import cam_geom_pkg::*, cam_bist_ops_pkg::*;
();

  // Command strobe
  logic                 valid;
  // Write, read or search
  bist_op_e             op;
  // Entry address, also selects the expected match line
  logic [RF_AWIDTH-1:0] addr;
  // Write data or search key
  logic [RF_DWIDTH-1:0] data;
  // Expected search pattern
  match_sel_e           match_sel;

  // Top level drives the command
  modport src (output valid, output op, output addr, output data, output match_sel);

  // CAM array only observes
  modport cam (input valid, input op, input addr, input data);

  // Expected-match generator observes address and pattern
  modport ref_gen (input valid, input addr, input match_sel);

endinterface

// File: source/cam_rsp_if.sv
/*
  Pipelined CAM array result toward the output handler.
  All fields are meaningful only while valid is high.
*/
interface cam_rsp_if import cam_geom_pkg::*, cam_bist_ops_pkg::*;
();

  // Result strobe, read or search only
  logic                  valid;
  // Op of the command that made this result
  bist_op_e              op;
  // Entry data at the command address
  logic [RF_DWIDTH-1:0]  rd_data;
  // Raw match lines from the array
  logic [RF_ENTRIES-1:0] match_lines;

  // CAM array side
  modport cam (output valid, output op, output rd_data, output match_lines);

  // Output handler side
  modport oh (input valid, input op, input rd_data, input match_lines);

endinterface

// File: sources.f
source/cam_geom_pkg.sv
source/cam_bist_ops_pkg.sv
source/cam_req_if.sv
source/cam_rsp_if.sv
source/cam_array.sv
source/cam_match_ref_gen.sv
source/cam_bist_outhandler.sv
source/cam_bist_top.sv
dv/cam_bist_tb.sv
